// ==== fht_1d_x8.f ====
+incdir+source
source/fht_data_pkg.sv
source/fht_ctrl_pkg.sv
source/fht_bfly.sv
source/fht_input_align.sv
source/fht_even_path.sv
source/fht_odd_path.sv
source/fht_out_serial.sv
source/fht_1d_x8.sv
test/tb_fht_1d_x8.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the FHT testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 -Wno-fatal \
	--top-module tb_fht_1d_x8 \
	-f fht_1d_x8.f \
	--Mdir obj_dir -o sim_fht_1d_x8

# $fatal gives a nonzero exit status, which set -e passes on
./obj_dir/sim_fht_1d_x8

// ==== source/fht_1d_x8.sv ====
/*
 * 8-point 1D FHT top: aligner, even and odd halves, serializer
 */
`timescale 1ns/1ps

module fht_1d_x8
	import fht_data_pkg::*;
(
	input  logic     sclk,
	input  logic     rstn,
	input  logic     x_valid,
	input  fht_in_t  x_data,
	output logic     fht_valid,
	output fht_out_t fht_data
);

	// Block strobe and first stage outputs
	logic     blk_valid;
	fht_s1_t  a0, a1, a2, a3;
	fht_s1_t  b0, b1, b2, b3;

	// Coefficients and their common strobe
	logic     stg_valid;
	fht_out_t h0, h1, h2, h3, h4, h5, h6, h7;

	fht_input_align u_input_align (
		.sclk(sclk), .rstn(rstn),
		.x_valid(x_valid), .x_data(x_data),
		.blk_valid(blk_valid),
		.a0(a0), .a1(a1), .a2(a2), .a3(a3),
		.b0(b0), .b1(b1), .b2(b2), .b3(b3)
	);

	fht_even_path u_even_path (
		.sclk(sclk), .rstn(rstn), .blk_valid(blk_valid),
		.a0(a0), .a1(a1), .a2(a2), .a3(a3),
		.stg_valid(stg_valid),
		.h0(h0), .h2(h2), .h4(h4), .h6(h6)
	);

	fht_odd_path u_odd_path (
		.sclk(sclk), .rstn(rstn), .blk_valid(blk_valid),
		.b0(b0), .b1(b1), .b2(b2), .b3(b3),
		.h1(h1), .h3(h3), .h5(h5), .h7(h7)
	);

	fht_out_serial u_out_serial (
		.sclk(sclk), .rstn(rstn), .stg_valid(stg_valid),
		.h0(h0), .h1(h1), .h2(h2), .h3(h3),
		.h4(h4), .h5(h5), .h6(h6), .h7(h7),
		.fht_valid(fht_valid), .fht_data(fht_data)
	);

endmodule

// ==== source/fht_bfly.sv ====
/*
 * Registered two-point Hartley butterfly, sum and difference with one bit growth
 */
`timescale 1ns/1ps

module fht_bfly #(
	parameter int WIDTH = 9
) (
	input  logic                    sclk,
	input  logic                    rstn,
	input  logic                    en,
	input  logic signed [WIDTH-1:0] a,
	input  logic signed [WIDTH-1:0] b,
	output logic signed [WIDTH:0]   sum,
	output logic signed [WIDTH:0]   dif
);

	// Sign extended operands
	logic signed [WIDTH:0] a_x;
	logic signed [WIDTH:0] b_x;

	assign a_x = a;
	assign b_x = b;

	// Hold outputs between enables
	always_ff @(posedge sclk or negedge rstn) begin
		if (!rstn) begin
			sum <= '0;
			dif <= '0;
		end else if (en) begin
			sum <= a_x + b_x;
			dif <= a_x - b_x;
		end
	end

endmodule

// ==== source/fht_ctrl_pkg.sv ====
/*
 * Control encodings for the FHT output serializer
 */
package fht_ctrl_pkg;

	// Serializer FSM states
	typedef enum logic {
		SER_IDLE = 1'b0,
		SER_EMIT = 1'b1
	} fht_ser_state_e;

endpackage

// ==== source/fht_data_pkg.sv ====
/*
 * Signed data types for every stage of the 8-point FHT datapath
 */
`include "fht_params.svh"

package fht_data_pkg;

	// Raw input sample
	typedef logic signed [`FHT_IN_W-1:0] fht_in_t;

	// First stage sum or difference, one guard bit
	typedef logic signed [`FHT_IN_W:0] fht_s1_t;

	// Second stage result and scaled odd term
	typedef logic signed [`FHT_IN_W+1:0] fht_s2_t;

	// Final Hartley coefficient
	typedef logic signed [`FHT_IN_W+2:0] fht_out_t;

endpackage

// ==== source/fht_even_path.sv ====
/*
 * Even half of the flowgraph: stages 2 and 3 on the first stage sums,
 * gives h0, h2, h4, h6 and the stage valid strobe
 */
`timescale 1ns/1ps

module fht_even_path
	import fht_data_pkg::*;
(
	input  logic     sclk,
	input  logic     rstn,
	input  logic     blk_valid,
	input  fht_s1_t  a0,
	input  fht_s1_t  a1,
	input  fht_s1_t  a2,
	input  fht_s1_t  a3,
	output logic     stg_valid,
	output fht_out_t h0,
	output fht_out_t h2,
	output fht_out_t h4,
	output fht_out_t h6
);

	fht_s2_t c0, c1, d0, d1;
	// Third stage enable, one cycle behind blk_valid
	logic    en_s3;

	// Stage 3 results appear one cycle after en_s3
	always_ff @(posedge sclk or negedge rstn) begin
		if (!rstn) begin
			en_s3     <= 1'b0;
			stg_valid <= 1'b0;
		end else begin
			en_s3     <= blk_valid;
			stg_valid <= en_s3;
		end
	end

	// Stage 2
	fht_bfly #(.WIDTH($bits(fht_s1_t))) u_s2_c (
		.sclk(sclk), .rstn(rstn), .en(blk_valid), .a(a0), .b(a2), .sum(c0), .dif(d0)
	);
	fht_bfly #(.WIDTH($bits(fht_s1_t))) u_s2_d (
		.sclk(sclk), .rstn(rstn), .en(blk_valid), .a(a1), .b(a3), .sum(c1), .dif(d1)
	);

	// Stage 3
	fht_bfly #(.WIDTH($bits(fht_s2_t))) u_s3_04 (
		.sclk(sclk), .rstn(rstn), .en(en_s3), .a(c0), .b(c1), .sum(h0), .dif(h4)
	);
	fht_bfly #(.WIDTH($bits(fht_s2_t))) u_s3_26 (
		.sclk(sclk), .rstn(rstn), .en(en_s3), .a(d0), .b(d1), .sum(h2), .dif(h6)
	);

endmodule

// ==== source/fht_input_align.sv ====
/*
 * Input aligner: valid sample counter, serial to parallel capture,
 * combinational first butterfly stage
 */
`timescale 1ns/1ps
`include "fht_params.svh"

module fht_input_align
	import fht_data_pkg::*;
(
	input  logic    sclk,
	input  logic    rstn,
	input  logic    x_valid,
	input  fht_in_t x_data,
	output logic    blk_valid,
	output fht_s1_t a0,
	output fht_s1_t a1,
	output fht_s1_t a2,
	output fht_s1_t a3,
	output fht_s1_t b0,
	output fht_s1_t b1,
	output fht_s1_t b2,
	output fht_s1_t b3
);

	localparam int CNT_W = $clog2(`FHT_POINTS);

	logic [CNT_W-1:0] cnt;
	logic             last;
	// Older samples of the block, index 0 is the newest
	fht_in_t          sh [0:`FHT_POINTS-2];
	// Complete block in arrival order
	fht_in_t          xp [0:`FHT_POINTS-1];

	// Eighth valid sample closes the block
	assign last = x_valid && (cnt == CNT_W'(`FHT_POINTS - 1));

	always_ff @(posedge sclk or negedge rstn) begin
		if (!rstn) begin
			cnt       <= '0;
			blk_valid <= 1'b0;
		end else begin
			blk_valid <= last;
			if (x_valid)
				cnt <= cnt + 1'b1;
		end
	end

	// Shift in on every valid sample
	always_ff @(posedge sclk) begin
		if (x_valid) begin
			sh[0] <= x_data;
			for (int i = 1; i < `FHT_POINTS - 1; i++)
				sh[i] <= sh[i-1];
		end
	end

	// Parallel load together with the closing sample, oldest first
	always_ff @(posedge sclk) begin
		if (last) begin
			for (int i = 0; i < `FHT_POINTS - 1; i++)
				xp[i] <= sh[`FHT_POINTS-2-i];
			xp[`FHT_POINTS-1] <= x_data;
		end
	end

	// First stage, x_k against x_(k+4)
	assign a0 = fht_s1_t'(xp[0]) + fht_s1_t'(xp[4]);
	assign a1 = fht_s1_t'(xp[1]) + fht_s1_t'(xp[5]);
	assign a2 = fht_s1_t'(xp[2]) + fht_s1_t'(xp[6]);
	assign a3 = fht_s1_t'(xp[3]) + fht_s1_t'(xp[7]);
	assign b0 = fht_s1_t'(xp[0]) - fht_s1_t'(xp[4]);
	assign b1 = fht_s1_t'(xp[1]) - fht_s1_t'(xp[5]);
	assign b2 = fht_s1_t'(xp[2]) - fht_s1_t'(xp[6]);
	assign b3 = fht_s1_t'(xp[3]) - fht_s1_t'(xp[7]);

endmodule

// ==== source/fht_odd_path.sv ====
/*
 * Odd half of the flowgraph: square root of two scaling and stages 2 and 3
 * on the first stage differences, gives h1, h3, h5, h7
 */
`timescale 1ns/1ps
`include "fht_params.svh"

module fht_odd_path
	import fht_data_pkg::*;
(
	input  logic     sclk,
	input  logic     rstn,
	input  logic     blk_valid,
	input  fht_s1_t  b0,
	input  fht_s1_t  b1,
	input  fht_s1_t  b2,
	input  fht_s1_t  b3,
	output fht_out_t h1,
	output fht_out_t h3,
	output fht_out_t h5,
	output fht_out_t h7
);

	// Product needs the operand width plus the 9 bit signed constant
	localparam int PROD_W = $bits(fht_s1_t) + 9;

	fht_s2_t                  e, f;
	fht_s2_t                  m1, m2;
	logic signed [PROD_W-1:0] p1, p2;
	logic                     en_s3;

	// Constant multiply, exact before the shift
	assign p1 = b1 * PROD_W'(`FHT_SQRT2_Q);
	assign p2 = b3 * PROD_W'(`FHT_SQRT2_Q);

	// Arithmetic shift floors toward minus infinity
	// Registered alongside the stage 2 butterfly
	always_ff @(posedge sclk) begin
		if (blk_valid) begin
			m1 <= fht_s2_t'(p1 >>> `FHT_SQRT2_SH);
			m2 <= fht_s2_t'(p2 >>> `FHT_SQRT2_SH);
		end
	end

	// Own copy of the stage 3 enable, same delay as the even half
	always_ff @(posedge sclk or negedge rstn) begin
		if (!rstn)
			en_s3 <= 1'b0;
		else
			en_s3 <= blk_valid;
	end

	// Stage 2, e and f
	fht_bfly #(.WIDTH($bits(fht_s1_t))) u_s2_ef (
		.sclk(sclk), .rstn(rstn), .en(blk_valid), .a(b0), .b(b2), .sum(e), .dif(f)
	);

	// Stage 3
	fht_bfly #(.WIDTH($bits(fht_s2_t))) u_s3_15 (
		.sclk(sclk), .rstn(rstn), .en(en_s3), .a(e), .b(m1), .sum(h1), .dif(h5)
	);
	fht_bfly #(.WIDTH($bits(fht_s2_t))) u_s3_37 (
		.sclk(sclk), .rstn(rstn), .en(en_s3), .a(f), .b(m2), .sum(h3), .dif(h7)
	);

endmodule

// ==== source/fht_out_serial.sv ====
/*
 * Output serializer: captures eight coefficients, streams h0 to h7
 */
`timescale 1ns/1ps
`include "fht_params.svh"

module fht_out_serial
	import fht_data_pkg::*;
	import fht_ctrl_pkg::*;
(
	input  logic     sclk,
	input  logic     rstn,
	input  logic     stg_valid,
	input  fht_out_t h0,
	input  fht_out_t h1,
	input  fht_out_t h2,
	input  fht_out_t h3,
	input  fht_out_t h4,
	input  fht_out_t h5,
	input  fht_out_t h6,
	input  fht_out_t h7,
	output logic     fht_valid,
	output fht_out_t fht_data
);

	localparam int IDX_W = $clog2(`FHT_POINTS);

	fht_ser_state_e   state;
	logic [IDX_W-1:0] idx;
	// Holding bank in output order
	fht_out_t         bank [0:`FHT_POINTS-1];

	// Bank capture, old contents still read on the same edge
	always_ff @(posedge sclk) begin
		if (stg_valid) begin
			bank[0] <= h0;
			bank[1] <= h1;
			bank[2] <= h2;
			bank[3] <= h3;
			bank[4] <= h4;
			bank[5] <= h5;
			bank[6] <= h6;
			bank[7] <= h7;
		end
	end

	always_ff @(posedge sclk or negedge rstn) begin
		if (!rstn) begin
			state     <= SER_IDLE;
			idx       <= '0;
			fht_valid <= 1'b0;
			fht_data  <= '0;
		end else begin
			fht_valid <= (state == SER_EMIT);
			fht_data  <= (state == SER_EMIT) ? bank[idx] : '0;
			// New block always restarts at h0
			if (stg_valid) begin
				state <= SER_EMIT;
				idx   <= '0;
			end else if (state == SER_EMIT) begin
				idx <= idx + 1'b1;
				if (idx == IDX_W'(`FHT_POINTS - 1))
					state <= SER_IDLE;
			end
		end
	end

endmodule

// ==== source/fht_params.svh ====
/*
 * Global sizing for the 8-point FHT core: sample width, block length,
 * fixed-point square root of two constant
 */
`ifndef FHT_PARAMS_SVH
`define FHT_PARAMS_SVH

// Input sample width in bits
`define FHT_IN_W 8
// Samples per transform block
`define FHT_POINTS 8
// Square root of two in Q7 and its shift
`define FHT_SQRT2_Q 181
`define FHT_SQRT2_SH 7

`endif

// ==== test/tb_fht_1d_x8.sv ====
/*
 * Testbench for the 8-point FHT core: LFSR stimulus, reference transform,
 * output compare process and watchdog
 */
`timescale 1ns/1ps
`include "fht_params.svh"

module tb_fht_1d_x8;

	localparam int IN_W = `FHT_IN_W;
	localparam int PTS = `FHT_POINTS;
	localparam int OUT_W = `FHT_IN_W + 3;
	localparam int N_B2B = 6;
	localparam int N_GAP = 6;
	// Impulse, random runs, three extremes, block after the mid-block reset
	localparam int N_BLOCKS = 1 + N_B2B + N_GAP + 3 + 1;
	localparam int WATCHDOG_CYCLES = N_BLOCKS * 16 + 300;

	logic                    sclk;
	logic                    rstn;
	logic                    x_valid;
	logic [IN_W-1:0]         x_data;
	logic                    fht_valid;
	logic signed [OUT_W-1:0] fht_data;

	logic [15:0]             lfsr;
	// Expected coefficients in output order
	logic signed [OUT_W-1:0] exp_q [$];
	logic signed [OUT_W-1:0] exp_val;
	logic [IN_W*PTS-1:0]     col_blk;
	int                      col_cnt = 0;
	int                      push_k;
	int                      beat_pos = 0;
	int                      cyc = 0;
	// Set once a block has left the DUT since the last reset
	logic                    out_seen = 1'b0;

	fht_1d_x8 u_fht_1d_x8 (
		.sclk(sclk), .rstn(rstn), .x_valid(x_valid), .x_data(x_data),
		.fht_valid(fht_valid), .fht_data(fht_data)
	);

	initial begin
		sclk = 1'b0;
		forever #10 sclk = ~sclk;
	end

	// Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		logic [15:0] n;
		n = s >> 1;
		if (s[0])
			n = n ^ 16'hB400;
		return n;
	endfunction

	// One LFSR step per bit taken
	task automatic draw_bits(input int n, output logic [15:0] v);
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			v = {v[14:0], lfsr[0]};
			lfsr = lfsr_step(lfsr);
		end
	endtask

	// Coefficient k of one block, x0 in the low byte
	function automatic logic signed [OUT_W-1:0] fht_ref(
		input logic [IN_W*PTS-1:0] blk,
		input int                  k
	);
		int x [0:7];
		int a [0:3];
		int b [0:3];
		int h [0:7];
		int c0, c1, d0, d1, e, f, m1, m2;
		int i;
		for (i = 0; i < PTS; i++)
			x[i] = $signed(blk[i*IN_W +: IN_W]);
		for (i = 0; i < 4; i++) begin
			a[i] = x[i] + x[i+4];
			b[i] = x[i] - x[i+4];
		end
		c0 = a[0] + a[2];
		c1 = a[1] + a[3];
		d0 = a[0] - a[2];
		d1 = a[1] - a[3];
		e  = b[0] + b[2];
		f  = b[0] - b[2];
		// Floor of b * sqrt(2) in Q7
		m1 = (b[1] * `FHT_SQRT2_Q) >>> `FHT_SQRT2_SH;
		m2 = (b[3] * `FHT_SQRT2_Q) >>> `FHT_SQRT2_SH;
		h[0] = c0 + c1;
		h[4] = c0 - c1;
		h[2] = d0 + d1;
		h[6] = d0 - d1;
		h[1] = e + m1;
		h[5] = e - m1;
		h[3] = f + m2;
		h[7] = f - m2;
		return OUT_W'(h[k]);
	endfunction

	task automatic drive_sample(input logic [IN_W-1:0] v);
		@(posedge sclk);
		x_valid <= 1'b1;
		x_data  <= v;
	endtask

	task automatic drive_idle();
		@(posedge sclk);
		x_valid <= 1'b0;
		x_data  <= '0;
	endtask

	// Optional idle cycle before each sample
	task automatic send_block(input logic [IN_W*PTS-1:0] v, input bit gaps);
		logic [15:0] g;
		int i;
		for (i = 0; i < PTS; i++) begin
			if (gaps) begin
				draw_bits(1, g);
				if (g[0])
					drive_idle();
			end
			drive_sample(v[i*IN_W +: IN_W]);
		end
	endtask

	task automatic random_block(output logic [IN_W*PTS-1:0] v);
		logic [15:0] s;
		int i;
		for (i = 0; i < PTS; i++) begin
			draw_bits(IN_W, s);
			v[i*IN_W +: IN_W] = s[IN_W-1:0];
		end
	endtask

	task automatic apply_reset();
		@(posedge sclk);
		rstn    <= 1'b0;
		x_valid <= 1'b0;
		repeat (10) @(posedge sclk);
		rstn <= 1'b1;
	endtask

	// Wait until every expected coefficient has left the DUT
	task automatic wait_drain();
		@(posedge sclk);
		while (exp_q.size() != 0 || beat_pos != 0)
			@(posedge sclk);
		repeat (2) @(posedge sclk);
	endtask

	// Output data reads zero while no block has been emitted
	task automatic check_data_zero(input string phase);
		assert (fht_data == '0) else begin
			$display("[FAIL] fht_data %s: expected 0x000 actual 0x%h", phase, fht_data);
			$display("Verification failed");
			$fatal(1, "output data not cleared");
		end
	endtask

	// Input monitor, a reset drops the partial block
	always @(posedge sclk) begin
		if (!rstn) begin
			col_cnt = 0;
		end else if (x_valid) begin
			col_blk[col_cnt*IN_W +: IN_W] = x_data;
			col_cnt = col_cnt + 1;
			if (col_cnt == PTS) begin
				for (push_k = 0; push_k < PTS; push_k++)
					exp_q.push_back(fht_ref(col_blk, push_k));
				col_cnt = 0;
			end
		end
	end

	// Output compare
	always @(posedge sclk) begin
		cyc = cyc + 1;
		if (!rstn) begin
			beat_pos = 0;
			out_seen = 1'b0;
			// First edge only starts the reset
			if (cyc > 1) begin
				assert (fht_valid == 1'b0) else begin
					$display("[FAIL] fht_valid in reset: expected 0x0 actual 0x%h", fht_valid);
					$display("Verification failed");
					$fatal(1, "output valid during reset");
				end
				check_data_zero("in reset");
			end
		end else if (fht_valid) begin
			out_seen = 1'b1;
			assert (exp_q.size() != 0) begin
				exp_val = exp_q.pop_front();
				beat_pos = (beat_pos + 1) % PTS;
				assert (fht_data === exp_val) else begin
					$display("[FAIL] fht_data: expected 0x%h actual 0x%h", exp_val, fht_data);
					$display("Verification failed");
					$fatal(1, "coefficient mismatch");
				end
			end else begin
				$display("Output beat arrived with no input block pending");
				$display("Verification failed");
				$fatal(1, "unexpected output beat");
			end
		end else begin
			// Eight beats per block with no hole
			assert (beat_pos == 0) else begin
				$display("Output block broke off after %0d beats", beat_pos);
				$display("Verification failed");
				$fatal(1, "output block not contiguous");
			end
			// Reset value holds until the first block leaves
			if (!out_seen) begin
				check_data_zero("after reset");
			end
		end
	end

	initial begin
		logic [IN_W*PTS-1:0] blk;
		logic [15:0]         rnd;
		int                  i;
		rstn    = 1'b0;
		x_valid = 1'b0;
		x_data  = '0;
		lfsr    = 16'd11794;
		repeat (10) @(posedge sclk);
		rstn <= 1'b1;
		repeat (4) @(posedge sclk);
		// Impulse
		send_block({{(PTS-1){8'h00}}, 8'h01}, 1'b0);
		drive_idle();
		wait_drain();
		// Back to back, x_valid held high
		for (i = 0; i < N_B2B; i++) begin
			random_block(blk);
			send_block(blk, 1'b0);
		end
		drive_idle();
		wait_drain();
		// Random gaps in x_valid
		for (i = 0; i < N_GAP; i++) begin
			random_block(blk);
			send_block(blk, 1'b1);
		end
		drive_idle();
		wait_drain();
		// Full scale negative, full scale positive, alternating
		send_block({PTS{8'h80}}, 1'b0);
		send_block({PTS{8'h7F}}, 1'b0);
		send_block({(PTS/2){8'h80, 8'h7F}}, 1'b0);
		drive_idle();
		wait_drain();
		// Three samples, then reset
		for (i = 0; i < 3; i++) begin
			draw_bits(IN_W, rnd);
			drive_sample(rnd[IN_W-1:0]);
		end
		apply_reset();
		repeat (2) @(posedge sclk);
		random_block(blk);
		send_block(blk, 1'b0);
		drive_idle();
		wait_drain();
		repeat (4) @(posedge sclk);
		if (exp_q.size() == 0 && beat_pos == 0 && col_cnt == 0) begin
			$display("Verification passed");
			$finish;
		end else begin
			$display("Run ended with %0d expected coefficients still pending", exp_q.size());
			$display("Verification failed");
			$fatal(1, "pending output at end of run");
		end
	end

	// Watchdog
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge sclk);
		$display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Verification failed");
		$fatal(1, "watchdog timeout");
	end

endmodule
